//--- common/saturn_settings.svh
`ifndef SATURN_SETTINGS_SVH
`define SATURN_SETTINGS_SVH

////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////

// ddr port, half-word address
`define DDR_AW 27
// cpu side, byte address
`define CPU_AW 25
// ddr data path
`define DDR_DW 32
// one load stream beat
`define LOAD_DW 16

////////////////////////////////////////////////////////////
// region bases in ddr, half-word units
////////////////////////////////////////////////////////////

// rom, also the cart image target
`define ROM_BASE `DDR_AW'(0)
// work ram low
`define RAML_BASE `DDR_AW'(1 << 19)
// work ram high, 32-bit wide
`define RAMH_BASE `DDR_AW'(1 << 20)

////////////////////////////////////////////////////////////
// reset and timing values
////////////////////////////////////////////////////////////

// all six layers on
`define SCRN_EN_RESET 6'b11_1111
// pal change to new_vmode toggle, in clk_sys cycles
`define VMODE_DELAY 5000000

`endif

//--- common/mem_bus_pkg.sv
`include "saturn_settings.svh"

package mem_bus_pkg;

	////////////////////////////////////////////////////////////
	// ddr side
	////////////////////////////////////////////////////////////

	// one request, valid for a single cycle
	typedef struct packed {
		logic [`DDR_AW-1:0] addr;
		logic [`DDR_DW-1:0] wdata;
		// write lanes, zero on reads
		logic [3:0]         we;
		logic               rd;
		// 16-bit access, lanes 1:0 only
		logic               b16;
	} ddr_req_t;

	////////////////////////////////////////////////////////////
	// requester side
	////////////////////////////////////////////////////////////

	// cpu main memory bus, selects active low
	typedef struct packed {
		logic [`CPU_AW-1:0] addr;
		logic [`DDR_DW-1:0] wdata;
		logic [3:0]         dqm_n;
		logic               rom_cs_n;
		logic               raml_cs_n;
		logic               ramh_cs_n;
		logic               rd_n;
	} cpu_bus_t;

	// load stream beat from the external loader
	typedef struct packed {
		logic                wr;
		logic [`CPU_AW-1:0]  addr;
		logic [`LOAD_DW-1:0] data;
	} load_t;

	// shared by both requesters
	typedef enum logic [1:0] {
		br_idle      = 2'd0,
		br_issue     = 2'd1,
		br_wait_done = 2'd2
	} bridge_state_e;

endpackage

//--- common/video_ui_pkg.sv
package video_ui_pkg;

	// {v30, h40}
	typedef enum logic [1:0] {
		res_256x224 = 2'b00,
		res_320x224 = 2'b01,
		res_256x240 = 2'b10,
		res_320x240 = 2'b11
	} video_res_e;

	typedef struct packed {
		logic [7:0] arx;
		logic [7:0] ary;
	} aspect_t;

	// menu bits used here
	typedef struct packed {
		logic wide_169;
		logic corrected_320;
		logic pal;
	} ui_status_t;

	// toggle flips once per event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} ps2_event_t;

	// ps/2 set-2 codes, extended keys carry bit 8
	typedef enum logic [8:0] {
		key_f1    = 9'h005,
		key_f2    = 9'h006,
		key_f3    = 9'h004,
		key_f4    = 9'h00c,
		key_f5    = 9'h003,
		key_f6    = 9'h00b,
		key_pause = 9'h177
	} key_code_e;

endpackage

//--- mem_bridge/cart_loader.sv
`include "saturn_settings.svh"

module cart_loader (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   cart_download,
	input  mem_bus_pkg::load_t     load,
	input  logic                   ddr_busy,
	output mem_bus_pkg::ddr_req_t  req,
	output logic                   ioctl_wait
);

	mem_bus_pkg::bridge_state_e state;
	logic                       busy_q;
	logic                       beat;
	logic                       busy_fall;
	logic [`CPU_AW-1:0]         addr_q;
	logic [`LOAD_DW-1:0]        data_q;

	// only take a beat when nothing is in flight
	assign beat      = cart_download & load.wr & (state == mem_bus_pkg::br_idle);
	// busy falling edge ends the write
	assign busy_fall = busy_q & ~ddr_busy;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state  <= mem_bus_pkg::br_idle;
			busy_q <= 1'b0;
		end else begin
			busy_q <= ddr_busy;
			case (state)
				mem_bus_pkg::br_idle: begin
					if (beat)
						state <= mem_bus_pkg::br_issue;
				end
				// hold off while memory still busy
				mem_bus_pkg::br_issue: begin
					if (!ddr_busy)
						state <= mem_bus_pkg::br_wait_done;
				end
				mem_bus_pkg::br_wait_done: begin
					if (busy_fall)
						state <= mem_bus_pkg::br_idle;
				end
				default: state <= mem_bus_pkg::br_idle;
			endcase
		end
	end

	// beat payload
	always_ff @(posedge clk_sys) begin
		if (beat) begin
			addr_q <= load.addr;
			data_q <= load.data;
		end
	end

	////////////////////////////////////////////////////////////
	// request build
	////////////////////////////////////////////////////////////
	always_comb begin
		// byte address halved onto half-words
		req.addr  = `ROM_BASE + `DDR_AW'(addr_q[`CPU_AW-1:1]);
		// image is stored byte-swapped
		req.wdata = {{(`DDR_DW - `LOAD_DW){1'b0}}, data_q[7:0], data_q[15:8]};
		req.we    = (state == mem_bus_pkg::br_issue && !ddr_busy) ? 4'b0011 : 4'b0000;
		req.rd    = 1'b0;
		req.b16   = 1'b1;
	end

	// high from the cycle after the beat until busy has dropped
	assign ioctl_wait = (state != mem_bus_pkg::br_idle);

endmodule

//--- mem_bridge/cpu_mem_map.sv
`include "saturn_settings.svh"

module cpu_mem_map (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  mem_bus_pkg::cpu_bus_t  bus,
	input  logic                   grant,
	input  logic                   ddr_busy,
	output mem_bus_pkg::ddr_req_t  req,
	output logic                   mem_wait_n
);

	mem_bus_pkg::bridge_state_e state;
	mem_bus_pkg::ddr_req_t      next_req;
	mem_bus_pkg::ddr_req_t      req_q;
	logic                       busy_q;
	logic                       done_q;
	logic                       cs;
	logic                       access;
	logic                       start;
	logic                       fire;

	assign cs     = ~bus.rom_cs_n | ~bus.raml_cs_n | ~bus.ramh_cs_n;
	// read, or a write with at least one lane
	assign access = cs & (~bus.rd_n | (~bus.dqm_n != 4'b0000));
	// done_q masks the select still held on the release cycle
	assign start  = grant & access & ~done_q & (state == mem_bus_pkg::br_idle);
	assign fire   = (state == mem_bus_pkg::br_issue) & ~ddr_busy;

	////////////////////////////////////////////////////////////
	// region decode
	////////////////////////////////////////////////////////////
	always_comb begin
		next_req.wdata = bus.wdata;
		next_req.rd    = ~bus.rd_n;
		if (!bus.rom_cs_n) begin
			next_req.addr = `ROM_BASE + `DDR_AW'(bus.addr[18:1]);
			next_req.b16  = 1'b1;
		end else if (!bus.raml_cs_n) begin
			next_req.addr = `RAML_BASE + `DDR_AW'(bus.addr[19:1]);
			next_req.b16  = 1'b1;
		end else begin
			// 32-bit, even half-word pair
			next_req.addr = `RAMH_BASE + `DDR_AW'({bus.addr[19:2], 1'b0});
			next_req.b16  = 1'b0;
		end
		// no lanes on a read, low lanes only on 16-bit
		if (!bus.rd_n)
			next_req.we = 4'b0000;
		else if (next_req.b16)
			next_req.we = {2'b00, ~bus.dqm_n[1:0]};
		else
			next_req.we = ~bus.dqm_n;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state  <= mem_bus_pkg::br_idle;
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			busy_q <= ddr_busy;
			done_q <= (state == mem_bus_pkg::br_wait_done) & busy_q & ~ddr_busy;
			case (state)
				mem_bus_pkg::br_idle: begin
					if (start)
						state <= mem_bus_pkg::br_issue;
				end
				mem_bus_pkg::br_issue: begin
					if (fire)
						state <= mem_bus_pkg::br_wait_done;
				end
				// completion on busy falling
				mem_bus_pkg::br_wait_done: begin
					if (busy_q && !ddr_busy)
						state <= mem_bus_pkg::br_idle;
				end
				default: state <= mem_bus_pkg::br_idle;
			endcase
		end
	end

	// access captured once, cpu keeps it steady anyway
	always_ff @(posedge clk_sys) begin
		if (start)
			req_q <= next_req;
	end

	// strobes for the single issue cycle only
	always_comb begin
		req    = req_q;
		req.rd = req_q.rd & fire;
		req.we = fire ? req_q.we : 4'b0000;
	end

	assign mem_wait_n = (state == mem_bus_pkg::br_idle);

endmodule

//--- mem_bridge/mem_bridge.sv
`include "saturn_settings.svh"

module mem_bridge (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   cart_download,
	input  logic                   core_reset,
	input  mem_bus_pkg::load_t     load,
	input  mem_bus_pkg::cpu_bus_t  bus,
	input  logic                   ddr_busy,
	input  logic [`DDR_DW-1:0]     ddr_rdata,
	output mem_bus_pkg::ddr_req_t  ddr_req,
	output logic                   ioctl_wait,
	output logic                   mem_wait_n,
	output logic [`DDR_DW-1:0]     mem_rdata,
	output logic                   core_rst_n
);

	mem_bus_pkg::ddr_req_t ld_req;
	mem_bus_pkg::ddr_req_t cpu_req;
	mem_bus_pkg::ddr_req_t sel_req;
	logic                  grant;
	logic                  busy_q;
	logic                  rd_q;
	logic [3:0]            we_q;
	logic [`DDR_AW-1:0]    addr_q;
	logic [`DDR_DW-1:0]    wdata_q;
	logic                  b16_q;
	logic [`DDR_DW-1:0]    rdata_q;

	// cpu locked out for the whole download
	assign grant = ~cart_download;

	cart_loader u_cart_loader (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.cart_download (cart_download),
		.load          (load),
		.ddr_busy      (ddr_busy),
		.req           (ld_req),
		.ioctl_wait    (ioctl_wait)
	);

	cpu_mem_map u_cpu_mem_map (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.bus        (bus),
		.grant      (grant),
		.ddr_busy   (ddr_busy),
		.req        (cpu_req),
		.mem_wait_n (mem_wait_n)
	);

	////////////////////////////////////////////////////////////
	// master select and port register
	////////////////////////////////////////////////////////////
	assign sel_req = cart_download ? ld_req : cpu_req;

	// strobes
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd_q   <= 1'b0;
			we_q   <= 4'b0000;
			busy_q <= 1'b0;
		end else begin
			rd_q   <= sel_req.rd;
			we_q   <= sel_req.we;
			busy_q <= ddr_busy;
		end
	end

	// address and data
	always_ff @(posedge clk_sys) begin
		addr_q  <= sel_req.addr;
		wdata_q <= sel_req.wdata;
		b16_q   <= sel_req.b16;
	end

	always_comb begin
		ddr_req.addr  = addr_q;
		ddr_req.wdata = wdata_q;
		ddr_req.we    = we_q;
		ddr_req.rd    = rd_q;
		ddr_req.b16   = b16_q;
	end

	// read data held from completion, seen with mem_wait_n high
	always_ff @(posedge clk_sys) begin
		if (busy_q && !ddr_busy)
			rdata_q <= ddr_rdata;
	end

	assign mem_rdata  = rdata_q;
	assign core_rst_n = ~(core_reset | cart_download);

endmodule

//--- rtl/aspect_select.sv
module aspect_select (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic                      vblank_n,
	input  video_ui_pkg::video_res_e  resolution,
	input  video_ui_pkg::ui_status_t  status,
	output video_ui_pkg::aspect_t     aspect
);

	video_ui_pkg::video_res_e res_q;
	logic                     vbl_q;

	// lock for the whole frame, at end of vblank
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			vbl_q <= 1'b1;
			res_q <= video_ui_pkg::res_320x224;
		end else begin
			vbl_q <= vblank_n;
			if (!vbl_q && vblank_n)
				res_q <= resolution;
		end
	end

	////////////////////////////////////////////////////////////
	// ratio table
	////////////////////////////////////////////////////////////
	always_comb begin
		if (status.wide_169) begin
			aspect.arx = 8'd16;
			aspect.ary = 8'd9;
		end else begin
			case (res_q)
				video_ui_pkg::res_256x224: begin
					aspect.arx = 8'd64;
					aspect.ary = 8'd49;
				end
				// h40 narrower pixels when corrected
				video_ui_pkg::res_320x224: begin
					aspect.arx = status.corrected_320 ? 8'd10 : 8'd64;
					aspect.ary = status.corrected_320 ? 8'd7 : 8'd49;
				end
				video_ui_pkg::res_256x240: begin
					aspect.arx = 8'd128;
					aspect.ary = 8'd105;
				end
				default: begin
					aspect.arx = status.corrected_320 ? 8'd4 : 8'd128;
					aspect.ary = status.corrected_320 ? 8'd3 : 8'd105;
				end
			endcase
		end
	end

endmodule

//--- rtl/debug_hotkeys.sv
`include "saturn_settings.svh"

module debug_hotkeys (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  video_ui_pkg::ps2_event_t  key,
	output logic [5:0]                scrn_en,
	output logic                      pause_en
);

	logic toggle_q;
	logic fresh;

	// new event only when toggle flips, and only presses count
	assign fresh = (key.toggle != toggle_q) & key.pressed;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			toggle_q <= 1'b0;
			scrn_en  <= `SCRN_EN_RESET;
			pause_en <= 1'b0;
		end else begin
			toggle_q <= key.toggle;
			if (fresh) begin
				case (key.code)
					// f1..f6 map to layers 0..5
					video_ui_pkg::key_f1: begin
						scrn_en[0] <= ~scrn_en[0];
					end
					video_ui_pkg::key_f2: begin
						scrn_en[1] <= ~scrn_en[1];
					end
					video_ui_pkg::key_f3: begin
						scrn_en[2] <= ~scrn_en[2];
					end
					video_ui_pkg::key_f4: begin
						scrn_en[3] <= ~scrn_en[3];
					end
					video_ui_pkg::key_f5: begin
						scrn_en[4] <= ~scrn_en[4];
					end
					video_ui_pkg::key_f6: begin
						scrn_en[5] <= ~scrn_en[5];
					end
					video_ui_pkg::key_pause: begin
						pause_en <= ~pause_en;
					end
					// anything else ignored
					default: begin
						scrn_en <= scrn_en;
					end
				endcase
			end
		end
	end

endmodule

//--- rtl/vmode_notify.sv
`include "saturn_settings.svh"

module vmode_notify #(
	parameter int delay = `VMODE_DELAY
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic hold,
	input  logic pal,
	output logic new_vmode
);

	localparam int cnt_w = $clog2(delay + 1);

	logic [cnt_w-1:0] cnt;
	logic             pal_q;
	logic             pal_chg;

	assign pal_chg = (pal != pal_q) & ~hold;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt       <= '0;
			pal_q     <= 1'b0;
			new_vmode <= 1'b0;
		end else begin
			// pal tracked only outside hold
			if (!hold)
				pal_q <= pal;
			// restart on hold or a fresh change
			if (hold || pal_chg) begin
				cnt <= cnt_w'(delay);
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
				if (cnt == cnt_w'(1))
					new_vmode <= ~new_vmode;
			end
		end
	end

endmodule

//--- rtl/saturn_glue_top.sv
`include "saturn_settings.svh"

module saturn_glue_top #(
	parameter int vmode_delay = `VMODE_DELAY
) (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	// loader and cpu side
	input  logic                      cart_download,
	input  logic                      core_reset,
	input  mem_bus_pkg::load_t        load,
	input  mem_bus_pkg::cpu_bus_t     bus,
	output logic                      ioctl_wait,
	output logic                      mem_wait_n,
	output logic [`DDR_DW-1:0]        mem_rdata,
	output logic                      core_rst_n,
	// ddr port
	input  logic                      ddr_busy,
	input  logic [`DDR_DW-1:0]        ddr_rdata,
	output mem_bus_pkg::ddr_req_t     ddr_req,
	// video and ui
	input  logic                      vblank_n,
	input  video_ui_pkg::video_res_e  resolution,
	input  video_ui_pkg::ui_status_t  status,
	input  video_ui_pkg::ps2_event_t  key,
	output video_ui_pkg::aspect_t     aspect,
	output logic [5:0]                scrn_en,
	output logic                      pause_en,
	output logic                      new_vmode
);

	mem_bridge u_mem_bridge (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.cart_download (cart_download),
		.core_reset    (core_reset),
		.load          (load),
		.bus           (bus),
		.ddr_busy      (ddr_busy),
		.ddr_rdata     (ddr_rdata),
		.ddr_req       (ddr_req),
		.ioctl_wait    (ioctl_wait),
		.mem_wait_n    (mem_wait_n),
		.mem_rdata     (mem_rdata),
		.core_rst_n    (core_rst_n)
	);

	aspect_select u_aspect_select (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.vblank_n   (vblank_n),
		.resolution (resolution),
		.status     (status),
		.aspect     (aspect)
	);

	debug_hotkeys u_debug_hotkeys (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.key      (key),
		.scrn_en  (scrn_en),
		.pause_en (pause_en)
	);

	// download holds off the notification
	vmode_notify #(
		.delay (vmode_delay)
	) u_vmode_notify (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.hold      (cart_download),
		.pal       (status.pal),
		.new_vmode (new_vmode)
	);

endmodule

//--- tests/saturn_glue_checker.sv
module saturn_glue_checker (
	input logic                  clk_sys,
	input logic                  rst_n,
	input mem_bus_pkg::ddr_req_t ddr_req,
	input logic                  ddr_busy,
	input logic                  ioctl_wait,
	input logic                  mem_wait_n
);

	// failures seen so far, read by the testbench at the end
	int fail_count = 0;

	////////////////////////////////////////////////////////////
	// ddr handshake
	////////////////////////////////////////////////////////////

	// a request is a read or a write, never both
	rd_or_lanes: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(ddr_req.rd && ddr_req.we != 4'b0000))
		else begin
			fail_count++;
			$error("ddr request carries read strobe and write lanes together");
		end

	// back-pressure is busy alone
	no_req_busy: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ddr_req.rd || ddr_req.we != 4'b0000) |-> !ddr_busy)
		else begin
			fail_count++;
			$error("ddr request issued while memory busy");
		end

	// control outputs quiet right out of reset
	reset_quiet: assert property (@(posedge clk_sys)
		$rose(rst_n) |-> (!ioctl_wait && mem_wait_n && !ddr_req.rd && ddr_req.we == 4'b0000))
		else begin
			fail_count++;
			$error("control outputs active after reset release");
		end

endmodule

bind mem_bridge saturn_glue_checker u_checker (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.ddr_req    (ddr_req),
	.ddr_busy   (ddr_busy),
	.ioctl_wait (ioctl_wait),
	.mem_wait_n (mem_wait_n)
);

//--- tests/saturn_glue_tb.sv
`include "saturn_settings.svh"

module saturn_glue_tb;

	typedef enum logic [3:0] {
		op_download, op_load, op_rom_rd, op_raml_wr, op_raml_rd,
		op_ramh_wr, op_ramh_rd, op_aspect, op_key, op_pal
	} op_e;

	// addr, data and exp meaning depends on op
	typedef struct packed {
		op_e         op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp;
	} step_t;

	localparam int n_steps    = 46;
	localparam int wait_limit = 100;

	logic                     clk_sys;
	logic                     rst_n;
	logic                     cart_download;
	logic                     core_reset;
	mem_bus_pkg::load_t       load;
	mem_bus_pkg::cpu_bus_t    bus;
	logic                     ioctl_wait;
	logic                     mem_wait_n;
	logic [`DDR_DW-1:0]       mem_rdata;
	logic                     core_rst_n;
	logic                     ddr_busy;
	logic [`DDR_DW-1:0]       ddr_rdata;
	mem_bus_pkg::ddr_req_t    ddr_req;
	logic                     vblank_n;
	video_ui_pkg::video_res_e resolution;
	video_ui_pkg::ui_status_t status;
	video_ui_pkg::ps2_event_t key;
	video_ui_pkg::aspect_t    aspect;
	logic [5:0]               scrn_en;
	logic                     pause_en;
	logic                     new_vmode;

	int checks   = 0;
	int errors   = 0;
	int timeouts = 0;
	int asserts  = 0;

	// ddr model state
	logic [15:0]        ddr_mem [logic [`DDR_AW-1:0]];
	int                 busy_left;
	logic [`DDR_DW-1:0] rd_pending;

	////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////
	step_t steps [n_steps] = '{
		'{op_download, 32'h0, 32'h1, 32'h0},
		// pal change under download gives no toggle
		'{op_pal, 32'h0, 32'h1, 32'h0},
		'{op_load, 32'h0000_0000, 32'h1234, 32'h3412},
		'{op_load, 32'h0000_0002, 32'habcd, 32'hcdab},
		'{op_load, 32'h0000_0010, 32'h0f5a, 32'h5a0f},
		'{op_load, 32'h0007_fffe, 32'h8001, 32'h0180},
		'{op_download, 32'h0, 32'h0, 32'h1},
		'{op_rom_rd, 32'h0000_0002, 32'h0, 32'h0000_cdab},
		'{op_rom_rd, 32'h0000_0010, 32'h0, 32'h0000_5a0f},
		'{op_rom_rd, 32'h0007_fffe, 32'h0, 32'h0000_0180},
		'{op_raml_wr, 32'h0000_0100, 32'h0000_4c3e, 32'h0000_4c3e},
		'{op_raml_wr, 32'h000f_fffe, 32'h0000_e1d2, 32'h0000_e1d2},
		'{op_raml_rd, 32'h0000_0100, 32'h0, 32'h0000_4c3e},
		'{op_raml_rd, 32'h000f_fffe, 32'h0, 32'h0000_e1d2},
		'{op_ramh_wr, 32'h0000_0200, 32'h1122_3344, 32'h1122_3344},
		'{op_ramh_wr, 32'h000f_fffc, 32'hdead_beef, 32'hdead_beef},
		'{op_ramh_rd, 32'h0000_0200, 32'h0, 32'h1122_3344},
		'{op_ramh_rd, 32'h000f_fffc, 32'h0, 32'hdead_beef},
		// resolution, {wide_169, corrected_320}, {arx, ary}
		'{op_aspect, 32'h0, 32'h0, 32'h4031},
		'{op_aspect, 32'h0, 32'h1, 32'h4031},
		'{op_aspect, 32'h0, 32'h2, 32'h1009},
		'{op_aspect, 32'h0, 32'h3, 32'h1009},
		'{op_aspect, 32'h1, 32'h0, 32'h4031},
		'{op_aspect, 32'h1, 32'h1, 32'h0a07},
		'{op_aspect, 32'h1, 32'h2, 32'h1009},
		'{op_aspect, 32'h1, 32'h3, 32'h1009},
		'{op_aspect, 32'h2, 32'h0, 32'h8069},
		'{op_aspect, 32'h2, 32'h1, 32'h8069},
		'{op_aspect, 32'h2, 32'h2, 32'h1009},
		'{op_aspect, 32'h2, 32'h3, 32'h1009},
		'{op_aspect, 32'h3, 32'h0, 32'h8069},
		'{op_aspect, 32'h3, 32'h1, 32'h0403},
		'{op_aspect, 32'h3, 32'h2, 32'h1009},
		'{op_aspect, 32'h3, 32'h3, 32'h1009},
		// code, {flip toggle, pressed}, {pause_en, scrn_en}
		'{op_key, 32'h005, 32'h3, 32'h3e},
		'{op_key, 32'h005, 32'h2, 32'h3e},
		'{op_key, 32'h004, 32'h3, 32'h3a},
		'{op_key, 32'h004, 32'h1, 32'h3a},
		'{op_key, 32'h00b, 32'h3, 32'h1a},
		'{op_key, 32'h177, 32'h3, 32'h5a},
		'{op_key, 32'h01c, 32'h3, 32'h5a},
		'{op_key, 32'h006, 32'h3, 32'h58},
		'{op_key, 32'h00c, 32'h3, 32'h50},
		'{op_key, 32'h003, 32'h3, 32'h40},
		// new pal level, delay in cycles
		'{op_pal, 32'h0, 32'h0, 32'd20},
		'{op_pal, 32'h0, 32'h1, 32'd20}
	};

	saturn_glue_top #(
		.vmode_delay (20)
	) UUT (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.cart_download (cart_download),
		.core_reset    (core_reset),
		.load          (load),
		.bus           (bus),
		.ioctl_wait    (ioctl_wait),
		.mem_wait_n    (mem_wait_n),
		.mem_rdata     (mem_rdata),
		.core_rst_n    (core_rst_n),
		.ddr_busy      (ddr_busy),
		.ddr_rdata     (ddr_rdata),
		.ddr_req       (ddr_req),
		.vblank_n      (vblank_n),
		.resolution    (resolution),
		.status        (status),
		.key           (key),
		.aspect        (aspect),
		.scrn_en       (scrn_en),
		.pause_en      (pause_en),
		.new_vmode     (new_vmode)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// ddr memory model
	////////////////////////////////////////////////////////////

	// unwritten half-words read a pattern over the whole address
	function automatic logic [15:0] peek(input logic [`DDR_AW-1:0] a);
		if (ddr_mem.exists(a))
			return ddr_mem[a];
		return 16'(a) ^ 16'(a >> 11) ^ 16'h5a3c;
	endfunction

	task automatic put_half(input logic [`DDR_AW-1:0] a, input logic [15:0] d,
		input logic [1:0] lanes);
		logic [15:0] w;
		w = peek(a);
		if (lanes[0])
			w[7:0] = d[7:0];
		if (lanes[1])
			w[15:8] = d[15:8];
		ddr_mem[a] = w;
	endtask

	// busy from the cycle after a request for 1 to 6 cycles
	// read data comes with the fall
	always @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ddr_busy  <= 1'b0;
			ddr_rdata <= '0;
			busy_left <= 0;
		end else if (busy_left > 1) begin
			busy_left <= busy_left - 1;
		end else if (busy_left == 1) begin
			busy_left <= 0;
			ddr_busy  <= 1'b0;
			ddr_rdata <= rd_pending;
		end else if (ddr_req.rd || ddr_req.we != 4'b0000) begin
			ddr_busy  <= 1'b1;
			busy_left <= 1 + int'($urandom % 6);
			if (ddr_req.b16) begin
				rd_pending <= {16'h0, peek(ddr_req.addr)};
				if (!ddr_req.rd)
					put_half(ddr_req.addr, ddr_req.wdata[15:0], ddr_req.we[1:0]);
			end else begin
				// upper half at A, lower half at A+1
				rd_pending <= {peek(ddr_req.addr), peek(ddr_req.addr + 1'b1)};
				if (!ddr_req.rd) begin
					put_half(ddr_req.addr, ddr_req.wdata[31:16], ddr_req.we[3:2]);
					put_half(ddr_req.addr + 1'b1, ddr_req.wdata[15:0], ddr_req.we[1:0]);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic mem_bus_pkg::cpu_bus_t idle_bus();
		mem_bus_pkg::cpu_bus_t b;
		b = '0;
		b.dqm_n     = 4'hf;
		b.rom_cs_n  = 1'b1;
		b.raml_cs_n = 1'b1;
		b.ramh_cs_n = 1'b1;
		b.rd_n      = 1'b1;
		return b;
	endfunction

	// half-word index within the region window plus the region base
	function automatic logic [`DDR_AW-1:0] ddr_addr(input op_e op, input logic [31:0] a);
		if (op == op_load)
			return `ROM_BASE + `DDR_AW'(a / 2);
		if (op == op_rom_rd)
			return `ROM_BASE + `DDR_AW'((a % (1 << 19)) / 2);
		if (op == op_raml_wr || op == op_raml_rd)
			return `RAML_BASE + `DDR_AW'((a % (1 << 20)) / 2);
		// 32-bit words, two half-words each
		return `RAMH_BASE + `DDR_AW'(((a % (1 << 20)) / 4) * 2);
	endfunction

	function automatic logic probe(input int sel);
		if (sel == 0)
			return ioctl_wait;
		return mem_wait_n;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// sampled on rising edges and returns on the edge where the level is seen
	task automatic wait_level(input int sel, input logic level, input string what);
		int n;
		n = 0;
		while (probe(sel) !== level && n < wait_limit) begin
			@(posedge clk_sys);
			n++;
		end
		if (probe(sel) !== level) begin
			timeouts++;
			$display("Timeout: %s not reached within %0d cycles", what, wait_limit);
		end
	endtask

	// select held until wait_n returns high
	task automatic cpu_access(input op_e op, input logic [31:0] addr, input logic [31:0] data);
		mem_bus_pkg::cpu_bus_t b;
		b       = idle_bus();
		b.addr  = addr[`CPU_AW-1:0];
		b.wdata = data;
		if (op == op_rom_rd)
			b.rom_cs_n = 1'b0;
		else if (op == op_raml_rd || op == op_raml_wr)
			b.raml_cs_n = 1'b0;
		else
			b.ramh_cs_n = 1'b0;
		if (op == op_raml_wr)
			b.dqm_n = 4'b1100;
		else if (op == op_ramh_wr)
			b.dqm_n = 4'b0000;
		else
			b.rd_n = 1'b0;
		@(posedge clk_sys);
		bus <= b;
		wait_level(1, 1'b0, "mem_wait_n low");
		wait_level(1, 1'b1, "mem_wait_n high");
		bus <= idle_bus();
	endtask

	task automatic run_step(input step_t s);
		logic [`DDR_AW-1:0] a;
		logic               start_v;
		int                 n;
		a = ddr_addr(s.op, s.addr);
		case (s.op)
			op_download: begin
				@(posedge clk_sys);
				cart_download <= s.data[0];
				@(posedge clk_sys);
				check("core_rst_n", {31'h0, core_rst_n}, s.exp);
			end
			// one beat followed by the wait pulse
			op_load: begin
				@(posedge clk_sys);
				load.wr   <= 1'b1;
				load.addr <= s.addr[`CPU_AW-1:0];
				load.data <= s.data[15:0];
				@(posedge clk_sys);
				load.wr <= 1'b0;
				wait_level(0, 1'b1, "ioctl_wait high");
				wait_level(0, 1'b0, "ioctl_wait low");
				check("ddr_mem", {16'h0, peek(a)}, s.exp);
			end
			op_rom_rd, op_raml_rd, op_ramh_rd: begin
				cpu_access(s.op, s.addr, s.data);
				check("mem_rdata", mem_rdata, s.exp);
			end
			op_raml_wr: begin
				cpu_access(s.op, s.addr, s.data);
				check("ddr_mem", {16'h0, peek(a)}, s.exp);
			end
			op_ramh_wr: begin
				cpu_access(s.op, s.addr, s.data);
				check("ddr_mem[A]", {16'h0, peek(a)}, {16'h0, s.exp[31:16]});
				check("ddr_mem[A+1]", {16'h0, peek(a + 1'b1)}, {16'h0, s.exp[15:0]});
			end
			// short vblank with the lock on the rise
			op_aspect: begin
				@(posedge clk_sys);
				resolution           <= video_ui_pkg::video_res_e'(s.addr[1:0]);
				status.wide_169      <= s.data[1];
				status.corrected_320 <= s.data[0];
				vblank_n             <= 1'b0;
				@(posedge clk_sys);
				vblank_n <= 1'b1;
				repeat (2) @(posedge clk_sys);
				check("aspect", {16'h0, aspect}, s.exp);
			end
			op_key: begin
				@(posedge clk_sys);
				key.code    <= s.addr[8:0];
				key.pressed <= s.data[0];
				if (s.data[1])
					key.toggle <= ~key.toggle;
				repeat (2) @(posedge clk_sys);
				check("scrn_en/pause_en", {25'h0, pause_en, scrn_en}, s.exp);
			end
			default: begin
				@(posedge clk_sys);
				status.pal <= s.data[0];
				start_v = new_vmode;
				n = 0;
				while (new_vmode === start_v && n < 40) begin
					@(posedge clk_sys);
					n++;
				end
				// one edge to see the change and one to sample the toggle
				check("new_vmode delay", (new_vmode !== start_v) ? n - 2 : 0, s.exp);
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial begin
		void'($urandom(32'he76b));
		rst_n         = 1'b0;
		cart_download = 1'b0;
		core_reset    = 1'b0;
		load          = '0;
		bus           = idle_bus();
		ddr_busy      = 1'b0;
		ddr_rdata     = '0;
		vblank_n      = 1'b1;
		// input mode differs from the reset lock until the first vblank rise
		resolution    = video_ui_pkg::res_256x240;
		// corrected h40 gives each locked mode its own ratio
		status        = '{wide_169: 1'b0, corrected_320: 1'b1, pal: 1'b0};
		key           = '0;
		repeat (8) @(posedge clk_sys);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk_sys);
		// reset values
		check("ioctl_wait", {31'h0, ioctl_wait}, 32'h0);
		check("mem_wait_n", {31'h0, mem_wait_n}, 32'h1);
		check("ddr_req.rd", {31'h0, ddr_req.rd}, 32'h0);
		check("ddr_req.we", {28'h0, ddr_req.we}, 32'h0);
		check("scrn_en", {26'h0, scrn_en}, {26'h0, `SCRN_EN_RESET});
		check("pause_en", {31'h0, pause_en}, 32'h0);
		check("new_vmode", {31'h0, new_vmode}, 32'h0);
		check("aspect", {16'h0, aspect}, 32'h0000_0a07);
		foreach (steps[i])
			run_step(steps[i]);
		repeat (4) @(posedge clk_sys);
		asserts = UUT.u_mem_bridge.u_checker.fail_count;
		$display("checks=%0d errors=%0d timeouts=%0d assertion failures=%0d",
			checks, errors, timeouts, asserts);
		if (errors == 0 && timeouts == 0 && asserts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+common
common/mem_bus_pkg.sv
common/video_ui_pkg.sv
mem_bridge/cart_loader.sv
mem_bridge/cpu_mem_map.sv
mem_bridge/mem_bridge.sv
rtl/aspect_select.sv
rtl/debug_hotkeys.sv
rtl/vmode_notify.sv
rtl/saturn_glue_top.sv
tests/saturn_glue_checker.sv
tests/saturn_glue_tb.sv
